// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mesh_line
FILELIST  := mesh_line.f
OBJ_DIR   := obj_dir

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

// File: mesh_hop.sv
// ~~~~~~~~~~~~~~~~~~~~
// One direction of a node with its input queue,
// word operation, hop increment and credit counter.
// ~~~~~~~~~~~~~~~~~~~~

module mesh_hop #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                clock,
    input  logic                rst,
    input  mesh_pkg::node_cfg_t cfg,
    mesh_link_if.receiver       up,
    mesh_link_if.sender         down
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    // One spare bit so a surplus credit shows up in the assertion and does not wrap.
    localparam int CNT_W = $clog2(BUF_DEPTH + 1) + 1;

    mesh_pkg::flit_t  mem [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] credits;

    logic             empty;
    logic             full;
    logic             has_credit;
    logic             bypass;
    logic             push;
    logic             pop;
    logic             send;
    mesh_pkg::flit_t  in_flit;
    mesh_pkg::flit_t  src_flit;

    logic             out_valid;
    mesh_pkg::flit_t  out_flit;
    logic             credit_q;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(BUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    function automatic mesh_pkg::word_t apply_op(input mesh_pkg::node_cfg_t c,
                                                 input mesh_pkg::word_t     d);
        case (c.op)
            mesh_pkg::OP_ADD: return d + c.operand;
            mesh_pkg::OP_XOR: return d ^ c.operand;
            default:          return d;
        endcase
    endfunction

    assign in_flit    = '{data: up.data, hops: up.hops};
    assign empty      = (count == '0);
    assign full       = (count == CNT_W'(BUF_DEPTH));
    assign has_credit = (credits != '0);

    // An arriving word skips an empty queue and goes straight to the output stage.
    // Anything already queued leaves first, so order is kept.
    assign bypass   = up.valid && empty && has_credit;
    assign pop      = !empty && has_credit;
    assign push     = up.valid && !bypass;
    assign send     = pop || bypass;
    assign src_flit = pop ? mem[rd_ptr] : in_flit;

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= CNT_W'(BUF_DEPTH);
            out_valid <= 1'b0;
            credit_q  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count     <= count + CNT_W'(push) - CNT_W'(pop);
            credits   <= credits - CNT_W'(send) + CNT_W'(down.credit);
            out_valid <= send;
            // Every word handed on frees one slot upstream.
            credit_q  <= send;
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_flit;
        end
        if (send) begin
            out_flit <= '{data: apply_op(cfg, src_flit.data),
                          hops: src_flit.hops + mesh_pkg::hop_t'(1)};
        end
    end

    assign down.valid = out_valid;
    assign down.data  = out_flit.data;
    assign down.hops  = out_flit.hops;
    assign up.credit  = credit_q;

    // The downstream queue never returns more credits than it has slots.
    a_credit_max: assert property (
        @(posedge clock) disable iff (rst) credits <= CNT_W'(BUF_DEPTH)
    ) else $error("mesh_hop: credit counter above BUF_DEPTH");

    // The upstream sender respects the credits this queue has handed out.
    a_no_overflow: assert property (
        @(posedge clock) disable iff (rst) up.valid |-> !full
    ) else $error("mesh_hop: word arrived at a full queue");

endmodule

// File: mesh_line.f
mesh_pkg.sv
mesh_link_if.sv
mesh_pipe.sv
mesh_hop.sv
mesh_node.sv
mesh_line.sv
tb_mesh_line.sv

// File: mesh_line.sv
// ~~~~~~~~~~~~~~~~~~~~
// Linear mesh top level with nodes joined by
// pipelined credit links in both directions.
// ~~~~~~~~~~~~~~~~~~~~

module mesh_line #(
    parameter int NODE_COUNT      = 4,
    parameter int EDGE_PIPE_DEPTH = 2,
    parameter int NODE_PIPE_DEPTH = 1,
    parameter int BUF_DEPTH       = 4
) (
    input  logic                      clock,
    input  logic                      rst,

    // Forward direction, entering at node 0.
    input  logic                      fwd_in_valid,
    input  mesh_pkg::word_t           fwd_in_data,
    output logic                      fwd_in_credit,
    output logic                      fwd_out_valid,
    output mesh_pkg::word_t           fwd_out_data,
    output mesh_pkg::hop_t            fwd_out_hops,
    input  logic                      fwd_out_credit,

    // Backward direction, entering at the last node.
    input  logic                      bwd_in_valid,
    input  mesh_pkg::word_t           bwd_in_data,
    output logic                      bwd_in_credit,
    output logic                      bwd_out_valid,
    output mesh_pkg::word_t           bwd_out_data,
    output mesh_pkg::hop_t            bwd_out_hops,
    input  logic                      bwd_out_credit,

    // Broadside configuration, one write enable per node.
    input  logic [NODE_COUNT-1:0]     cfg_wren,
    input  mesh_pkg::node_op_e        cfg_op,
    input  mesh_pkg::word_t           cfg_operand
);

    // Pipe k sits on the left of node k in both chains. Pipe 0 and pipe
    // NODE_COUNT are the edge segments.
    mesh_link_if fwd_pin  [0:NODE_COUNT] ();
    mesh_link_if fwd_pout [0:NODE_COUNT] ();
    mesh_link_if bwd_pin  [0:NODE_COUNT] ();
    mesh_link_if bwd_pout [0:NODE_COUNT] ();

    mesh_pkg::node_cfg_t cfg_bus;

    assign cfg_bus = '{op: cfg_op, operand: cfg_operand};

    genvar k;

    generate
        for (k = 0; k <= NODE_COUNT; k++) begin : g_pipe
            localparam int SEG_DEPTH = (k == 0 || k == NODE_COUNT) ? EDGE_PIPE_DEPTH
                                                                   : NODE_PIPE_DEPTH;

            mesh_pipe #(
                .DEPTH (SEG_DEPTH)
            ) fwd_pipe (
                .clock (clock),
                .rst   (rst),
                .up    (fwd_pin[k]),
                .down  (fwd_pout[k])
            );

            // Backward words run from the high side of a slot to the low side.
            mesh_pipe #(
                .DEPTH (SEG_DEPTH)
            ) bwd_pipe (
                .clock (clock),
                .rst   (rst),
                .up    (bwd_pin[k]),
                .down  (bwd_pout[k])
            );
        end

        for (k = 0; k < NODE_COUNT; k++) begin : g_node
            mesh_node #(
                .BUF_DEPTH (BUF_DEPTH)
            ) node (
                .clock     (clock),
                .rst       (rst),
                .cfg_wren  (cfg_wren[k]),
                .cfg_in    (cfg_bus),
                .fwd_up    (fwd_pout[k]),
                .fwd_down  (fwd_pin[k+1]),
                .bwd_up    (bwd_pout[k+1]),
                .bwd_down  (bwd_pin[k])
            );
        end
    endgenerate

    // Words enter with a hop count of zero.
    assign fwd_pin[0].valid = fwd_in_valid;
    assign fwd_pin[0].data  = fwd_in_data;
    assign fwd_pin[0].hops  = '0;
    assign fwd_in_credit    = fwd_pin[0].credit;

    assign fwd_out_valid             = fwd_pout[NODE_COUNT].valid;
    assign fwd_out_data              = fwd_pout[NODE_COUNT].data;
    assign fwd_out_hops              = fwd_pout[NODE_COUNT].hops;
    assign fwd_pout[NODE_COUNT].credit = fwd_out_credit;

    assign bwd_pin[NODE_COUNT].valid = bwd_in_valid;
    assign bwd_pin[NODE_COUNT].data  = bwd_in_data;
    assign bwd_pin[NODE_COUNT].hops  = '0;
    assign bwd_in_credit             = bwd_pin[NODE_COUNT].credit;

    assign bwd_out_valid    = bwd_pout[0].valid;
    assign bwd_out_data     = bwd_pout[0].data;
    assign bwd_out_hops     = bwd_pout[0].hops;
    assign bwd_pout[0].credit = bwd_out_credit;

    // The hop field has to count every node without wrapping.
    a_node_count: assert property (
        @(posedge clock) NODE_COUNT >= 1 && NODE_COUNT < (1 << mesh_pkg::HOP_WIDTH)
    ) else $error("mesh_line: NODE_COUNT must be between 1 and 15");

    // Every word leaving the line has passed through each node exactly once.
    a_hops_out: assert property (
        @(posedge clock) disable iff (rst)
        (fwd_out_valid |-> fwd_out_hops == mesh_pkg::hop_t'(NODE_COUNT)) and
        (bwd_out_valid |-> bwd_out_hops == mesh_pkg::hop_t'(NODE_COUNT))
    ) else $error("mesh_line: output hop count differs from NODE_COUNT");

endmodule

// File: mesh_link_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// Credit-flow link between neighbours,
// with sender and receiver modports.
// ~~~~~~~~~~~~~~~~~~~~

interface mesh_link_if;

    // Word qualifier. One valid cycle spends one credit at the sender.
    logic            valid;
    mesh_pkg::word_t data;
    mesh_pkg::hop_t  hops;

    // One-cycle pulse from the receiver each time a queue slot frees up.
    logic            credit;

    modport sender (
        output valid,
        output data,
        output hops,
        input  credit
    );

    modport receiver (
        input  valid,
        input  data,
        input  hops,
        output credit
    );

endinterface

// File: mesh_node.sv
// ~~~~~~~~~~~~~~~~~~~~
// Mesh node with its configuration register
// and one hop for each direction of the line.
// ~~~~~~~~~~~~~~~~~~~~

module mesh_node #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                cfg_wren,
    input  mesh_pkg::node_cfg_t cfg_in,
    mesh_link_if.receiver       fwd_up,
    mesh_link_if.sender         fwd_down,
    mesh_link_if.receiver       bwd_up,
    mesh_link_if.sender         bwd_down
);

    mesh_pkg::node_cfg_t cfg_q;

    // A node comes out of reset as a plain pass-through.
    always_ff @(posedge clock) begin
        if (rst) begin
            cfg_q <= '{op: mesh_pkg::OP_PASS, operand: '0};
        end else if (cfg_wren) begin
            cfg_q <= cfg_in;
        end
    end

    // Both directions apply the same operation with the same operand.
    mesh_hop #(
        .BUF_DEPTH (BUF_DEPTH)
    ) fwd_hop (
        .clock     (clock),
        .rst       (rst),
        .cfg       (cfg_q),
        .up        (fwd_up),
        .down      (fwd_down)
    );

    mesh_hop #(
        .BUF_DEPTH (BUF_DEPTH)
    ) bwd_hop (
        .clock     (clock),
        .rst       (rst),
        .cfg       (cfg_q),
        .up        (bwd_up),
        .down      (bwd_down)
    );

    // The opcode comes straight from the top-level ports.
    a_cfg_legal: assert property (
        @(posedge clock) disable iff (rst)
        cfg_wren |-> cfg_in.op inside {mesh_pkg::OP_PASS, mesh_pkg::OP_ADD, mesh_pkg::OP_XOR}
    ) else $error("mesh_node: illegal opcode written");

endmodule

// File: mesh_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~
// Pipelined link segment, flits going down
// and credit pulses going up, DEPTH stages each.
// ~~~~~~~~~~~~~~~~~~~~

module mesh_pipe #(
    parameter int DEPTH = 1
) (
    input  logic          clock,
    input  logic          rst,
    mesh_link_if.receiver up,
    mesh_link_if.sender   down
);

    generate
        if (DEPTH == 0) begin : g_wire
            assign down.valid = up.valid;
            assign down.data  = up.data;
            assign down.hops  = up.hops;
            assign up.credit  = down.credit;
        end else begin : g_stages
            logic [DEPTH-1:0] valid_q;
            logic [DEPTH-1:0] credit_q;
            mesh_pkg::flit_t  flit_q [DEPTH];

            always_ff @(posedge clock) begin
                if (rst) begin
                    valid_q  <= '0;
                    credit_q <= '0;
                end else begin
                    valid_q[0]  <= up.valid;
                    credit_q[0] <= down.credit;
                    for (int i = 1; i < DEPTH; i++) begin
                        valid_q[i]  <= valid_q[i-1];
                        credit_q[i] <= credit_q[i-1];
                    end
                end
            end

            always_ff @(posedge clock) begin
                flit_q[0] <= '{data: up.data, hops: up.hops};
                for (int i = 1; i < DEPTH; i++) begin
                    flit_q[i] <= flit_q[i-1];
                end
            end

            assign down.valid = valid_q[DEPTH-1];
            assign down.data  = flit_q[DEPTH-1].data;
            assign down.hops  = flit_q[DEPTH-1].hops;
            assign up.credit  = credit_q[DEPTH-1];
        end
    endgenerate

    // The upstream sender must come out of reset with a known valid.
    a_valid_known: assert property (
        @(posedge clock) disable iff (rst) !$isunknown(down.valid)
    ) else $error("mesh_pipe: valid is unknown after reset");

endmodule

// File: mesh_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared widths, word and hop types, flit layout
// and the node opcodes and configuration record.
// ~~~~~~~~~~~~~~~~~~~~

package mesh_pkg;

    // Width of a data word.
    localparam int WORD_WIDTH = 16;

    // Width of the hop count. Four bits allow a line of up to 15 nodes.
    localparam int HOP_WIDTH = 4;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [HOP_WIDTH-1:0]  hop_t;

    // A word in flight, with the number of nodes it has passed through.
    typedef struct packed {
        word_t data;
        hop_t  hops;
    } flit_t;

    // Operation a node applies to every word it forwards.
    typedef enum logic [1:0] {
        OP_PASS = 2'd0,
        OP_ADD  = 2'd1,
        OP_XOR  = 2'd2
    } node_op_e;

    // Per-node configuration, shared by both directions of the node.
    typedef struct packed {
        node_op_e op;
        word_t    operand;
    } node_cfg_t;

endpackage

// File: tb_mesh_line.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the mesh line with reference model, credit-keeping
// sources and sinks, output compare and watchdog.
// ~~~~~~~~~~~~~~~~~~~~

module tb_mesh_line;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NODE_COUNT     = 4;
    localparam int BUF_DEPTH      = 4;
    // Words injected over all tests, both directions together.
    localparam int TOTAL_WORDS    = 128;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_WORDS + 500;

    logic                clock = 1'b0;
    logic                rst;
    logic                fwd_in_valid;
    mesh_pkg::word_t     fwd_in_data;
    logic                fwd_in_credit;
    logic                fwd_out_valid;
    mesh_pkg::word_t     fwd_out_data;
    mesh_pkg::hop_t      fwd_out_hops;
    logic                fwd_out_credit;
    logic                bwd_in_valid;
    mesh_pkg::word_t     bwd_in_data;
    logic                bwd_in_credit;
    logic                bwd_out_valid;
    mesh_pkg::word_t     bwd_out_data;
    mesh_pkg::hop_t      bwd_out_hops;
    logic                bwd_out_credit;
    logic [NODE_COUNT-1:0] cfg_wren;
    mesh_pkg::node_op_e  cfg_op;
    mesh_pkg::word_t     cfg_operand;

    integer              seed;
    int                  cycles = 0;
    int                  src_credits [2];
    int                  sink_fill [2];
    bit                  stall_sinks;
    mesh_pkg::node_op_e  model_op [NODE_COUNT];
    mesh_pkg::word_t     model_operand [NODE_COUNT];
    mesh_pkg::flit_t     fwd_exp [$];
    mesh_pkg::flit_t     bwd_exp [$];

    mesh_line uut (
        .clock          (clock),
        .rst            (rst),
        .fwd_in_valid   (fwd_in_valid),
        .fwd_in_data    (fwd_in_data),
        .fwd_in_credit  (fwd_in_credit),
        .fwd_out_valid  (fwd_out_valid),
        .fwd_out_data   (fwd_out_data),
        .fwd_out_hops   (fwd_out_hops),
        .fwd_out_credit (fwd_out_credit),
        .bwd_in_valid   (bwd_in_valid),
        .bwd_in_data    (bwd_in_data),
        .bwd_in_credit  (bwd_in_credit),
        .bwd_out_valid  (bwd_out_valid),
        .bwd_out_data   (bwd_out_data),
        .bwd_out_hops   (bwd_out_hops),
        .bwd_out_credit (bwd_out_credit),
        .cfg_wren       (cfg_wren),
        .cfg_op         (cfg_op),
        .cfg_operand    (cfg_operand)
    );

    always #20 clock = ~clock;

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped after a failed check.");
    endtask

    task automatic check_word(input string name, input mesh_pkg::word_t expected,
                              input mesh_pkg::word_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERROR at %0d ns: %s expected %h, got %h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_hops(input string name, input mesh_pkg::hop_t expected,
                              input mesh_pkg::hop_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERROR at %0d ns: %s expected %h, got %h",
                                     $time, name, expected, actual));
        end
    endtask

    // Walks the word through every node in the order that direction visits them.
    function automatic mesh_pkg::flit_t expected_flit(input mesh_pkg::word_t d, input int dir);
        mesh_pkg::flit_t f;
        mesh_pkg::word_t v;
        int              n;
        int              i;
        v = d;
        for (i = 0; i < NODE_COUNT; i++) begin
            n = (dir == 0) ? i : NODE_COUNT - 1 - i;
            if (model_op[n] == mesh_pkg::OP_ADD) begin
                v = mesh_pkg::word_t'(v + model_operand[n]);
            end else if (model_op[n] == mesh_pkg::OP_XOR) begin
                v = v ^ model_operand[n];
            end
        end
        f.data = v;
        f.hops = mesh_pkg::hop_t'(NODE_COUNT);
        return f;
    endfunction

    task automatic compare_output(input int dir, input mesh_pkg::word_t data,
                                  input mesh_pkg::hop_t hops);
        mesh_pkg::flit_t exp_f;
        string           side;
        side = (dir == 0) ? "fwd" : "bwd";
        if ((dir == 0 && fwd_exp.size() == 0) || (dir == 1 && bwd_exp.size() == 0)) begin
            report_failure($sformatf("A %s word came out that was never sent.", side));
        end else if (sink_fill[dir] >= BUF_DEPTH) begin
            report_failure($sformatf("The %s sink received a word while full.", side));
        end else begin
            exp_f = (dir == 0) ? fwd_exp.pop_front() : bwd_exp.pop_front();
            sink_fill[dir]++;
            check_word({side, "_out_data"}, exp_f.data, data);
            check_hops({side, "_out_hops"}, exp_f.hops, hops);
        end
    endtask

    // Output values are sampled on the edge, before the DUT registers update.
    always @(posedge clock) begin
        if (!rst) begin
            if (fwd_out_valid) begin
                compare_output(0, fwd_out_data, fwd_out_hops);
            end
            if (bwd_out_valid) begin
                compare_output(1, bwd_out_data, bwd_out_hops);
            end
        end
    end

    // Credits come back from the line and valid cycles spend them.
    always @(posedge clock) begin
        if (rst) begin
            src_credits[0] = BUF_DEPTH;
            src_credits[1] = BUF_DEPTH;
        end else begin
            src_credits[0] = src_credits[0] + int'(fwd_in_credit) - int'(fwd_in_valid);
            src_credits[1] = src_credits[1] + int'(bwd_in_credit) - int'(bwd_in_valid);
            if (src_credits[0] > BUF_DEPTH || src_credits[1] > BUF_DEPTH) begin
                report_failure("The line returned more credits than the queue depth.");
            end
        end
    end

    // Sinks drain one word per cycle, or stall at random when asked to.
    always @(posedge clock) begin
        #2;
        fwd_out_credit = 1'b0;
        bwd_out_credit = 1'b0;
        if (rst) begin
            sink_fill[0] = 0;
            sink_fill[1] = 0;
        end else begin
            if (sink_fill[0] > 0 && (!stall_sinks || ($random(seed) & 1) != 0)) begin
                fwd_out_credit = 1'b1;
                sink_fill[0]--;
            end
            if (sink_fill[1] > 0 && (!stall_sinks || ($random(seed) & 1) != 0)) begin
                bwd_out_credit = 1'b1;
                sink_fill[1]--;
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the words sent did not all come out of the line in time.");
            $display("=== FAIL ===");
            $fatal(1, "Simulation stopped by the watchdog.");
        end
    end

    task automatic send_word(input int dir, input mesh_pkg::word_t d);
        bit sent;
        sent = 1'b0;
        while (!sent) begin
            @(posedge clock);
            #2;
            if (src_credits[dir] > 0) begin
                sent = 1'b1;
                if (dir == 0) begin
                    fwd_in_valid = 1'b1;
                    fwd_in_data  = d;
                    fwd_exp.push_back(expected_flit(d, 0));
                end else begin
                    bwd_in_valid = 1'b1;
                    bwd_in_data  = d;
                    bwd_exp.push_back(expected_flit(d, 1));
                end
            end else if (dir == 0) begin
                fwd_in_valid = 1'b0;
            end else begin
                bwd_in_valid = 1'b0;
            end
        end
    endtask

    task automatic send_burst(input int dir, input int count, input bit random_data);
        mesh_pkg::word_t d;
        for (int i = 0; i < count; i++) begin
            d = random_data ? mesh_pkg::word_t'($random(seed)) : mesh_pkg::word_t'(16'h0100 + i);
            send_word(dir, d);
        end
        @(posedge clock);
        #2;
        if (dir == 0) begin
            fwd_in_valid = 1'b0;
        end else begin
            bwd_in_valid = 1'b0;
        end
    endtask

    task automatic write_cfg(input int node, input mesh_pkg::node_op_e op,
                             input mesh_pkg::word_t operand);
        @(posedge clock);
        #2;
        cfg_wren            = NODE_COUNT'(1) << node;
        cfg_op              = op;
        cfg_operand         = operand;
        model_op[node]      = op;
        model_operand[node] = operand;
        @(posedge clock);
        #2;
        cfg_wren = '0;
    endtask

    // The line is idle once every word is out and all credits are home.
    task automatic wait_idle();
        do begin
            @(posedge clock);
            #2;
        end while (fwd_exp.size() != 0 || bwd_exp.size() != 0 ||
                   src_credits[0] != BUF_DEPTH || src_credits[1] != BUF_DEPTH ||
                   sink_fill[0] != 0 || sink_fill[1] != 0);
        repeat (4) @(posedge clock);
    endtask

    initial begin
        seed           = 59;
        stall_sinks    = 1'b0;
        rst            = 1'b1;
        fwd_in_valid   = 1'b0;
        fwd_in_data    = '0;
        fwd_out_credit = 1'b0;
        bwd_in_valid   = 1'b0;
        bwd_in_data    = '0;
        bwd_out_credit = 1'b0;
        cfg_wren       = '0;
        cfg_op         = mesh_pkg::OP_PASS;
        cfg_operand    = '0;
        for (int i = 0; i < NODE_COUNT; i++) begin
            model_op[i]      = mesh_pkg::OP_PASS;
            model_operand[i] = '0;
        end
        repeat (4) @(posedge clock);
        #2;
        rst = 1'b0;

        // All nodes pass words through untouched.
        send_burst(0, 8, 1'b0);
        wait_idle();

        write_cfg(0, mesh_pkg::OP_ADD, 16'h1234);
        write_cfg(1, mesh_pkg::OP_XOR, 16'h00ff);
        write_cfg(2, mesh_pkg::OP_ADD, 16'hf00d);
        write_cfg(3, mesh_pkg::OP_XOR, 16'ha5a5);
        send_burst(0, 8, 1'b1);
        wait_idle();

        fork
            send_burst(0, 8, 1'b1);
            send_burst(1, 8, 1'b1);
        join
        wait_idle();

        // Continuous injection against sinks that stall at random.
        stall_sinks = 1'b1;
        fork
            send_burst(0, 40, 1'b1);
            send_burst(1, 40, 1'b1);
        join
        wait_idle();
        stall_sinks = 1'b0;

        write_cfg(2, mesh_pkg::OP_XOR, 16'h5a5a);
        fork
            send_burst(0, 8, 1'b1);
            send_burst(1, 8, 1'b1);
        join
        wait_idle();

        $display("=== PASS ===");
        $finish;
    end

endmodule
